/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_lake_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* access_sched.sv */
`timescale 1ns/1ps

module access_sched (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  lake_pkg::time_t       cycle_count,
  input  lake_pkg::range_arr_t  ranges,
  input  lake_pkg::time_t       sched_start,
  input  lake_pkg::stride_arr_t sched_strides,
  input  lake_pkg::mem_addr_t   addr_start,
  input  lake_pkg::stride_arr_t addr_strides,
  output logic                  fire,
  output lake_pkg::mem_addr_t   addr
);
  import lake_pkg::*;

  loop_sel_t sel;
  time_t     sched_time;   // cycle of the next access

  assign fire = (sched_time == cycle_count);

  loop_iter iter (
    .clk    (clk),
    .rst_n  (rst_n),
    .flush  (flush),
    .step   (fire),
    .ranges (ranges),
    .sel    (sel)
  );

  // schedule and address move along the same loop point
  affine_gen #(
    .value_t (time_t)
  ) sched_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush   (flush),
    .step    (fire),
    .sel     (sel),
    .start   (sched_start),
    .strides (sched_strides),
    .value   (sched_time)
  );

  affine_gen #(
    .value_t (mem_addr_t)
  ) addr_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush   (flush),
    .step    (fire),
    .sel     (sel),
    .start   (addr_start),
    .strides (addr_strides),
    .value   (addr)
  );

endmodule

/* affine_gen.sv */
`timescale 1ns/1ps

module affine_gen #(
  parameter type value_t = logic [15:0]
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  step,
  input  lake_pkg::loop_sel_t   sel,
  input  value_t                start,
  input  lake_pkg::stride_arr_t strides,
  output value_t                value
);

  value_t offset;   // sum of strides taken so far

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      offset <= '0;
    end else if (flush) begin
      offset <= '0;
    end else if (step) begin
      // wraps at the width of value_t
      offset <= value_t'(offset + value_t'(strides[sel]));
    end
  end

  assign value = value_t'(start + offset);

endmodule

/* lake_chk.sv */
`timescale 1ns/1ps

module lake_chk (
  input logic clk,
  input logic rst_n,
  input logic flush,
  input logic wr_fire,
  input logic rd_fire,
  input logic config_req,
  input logic config_ack,
  input logic valid_out
);

  // read data leaves exactly one cycle after the fire
  valid_follows_read: assert property (@(posedge clk) disable iff (!rst_n)
    (rd_fire && !flush) |=> valid_out)
    else $error("valid_out missing one cycle after rd_fire");

  no_spurious_valid: assert property (@(posedge clk) disable iff (!rst_n)
    (!rd_fire || flush) |=> !valid_out)
    else $error("valid_out high without a read one cycle before");

  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(config_ack) |-> $past(config_req))
    else $error("config_ack rose without config_req");

  // four-phase release
  ack_holds_until_release: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(config_ack) |-> (!$past(config_req) || $past(flush)))
    else $error("config_ack fell while config_req still high");

  // streams always win the array
  stream_blocks_config: assert property (@(posedge clk) disable iff (!rst_n)
    (config_req && !config_ack && (wr_fire || rd_fire) && !flush) |=> !config_ack)
    else $error("config access granted in a stream cycle");

endmodule

bind lake_top lake_chk chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .flush      (flush),
  .wr_fire    (wr_fire),
  .rd_fire    (rd_fire),
  .config_req (config_req),
  .config_ack (config_ack),
  .valid_out  (valid_out)
);

/* lake_defs.svh */
`ifndef LAKE_DEFS_SVH
`define LAKE_DEFS_SVH

// word and memory geometry
`define LAKE_DATA_W    16
`define LAKE_MEM_DEPTH 256
`define LAKE_ADDR_W    8

// cycle count and schedule times share one width
`define LAKE_TIME_W    16

// loop nest shape
`define LAKE_LOOP_DIMS 6
`define LAKE_SEL_W     3   // enough to index every level

`endif

/* lake_pkg.sv */
`include "lake_defs.svh"

package lake_pkg;

  // one memory word
  typedef logic [`LAKE_DATA_W-1:0] data_t;

  typedef logic [`LAKE_ADDR_W-1:0] mem_addr_t;

  // cycle count and schedule times
  typedef logic [`LAKE_TIME_W-1:0] time_t;

  typedef logic [`LAKE_SEL_W-1:0] loop_sel_t;

  // jump from the previous point, one per level
  typedef logic [`LAKE_LOOP_DIMS-1:0][`LAKE_TIME_W-1:0] stride_arr_t;

  // last index of each level, counting from 0
  typedef logic [`LAKE_LOOP_DIMS-1:0][`LAKE_TIME_W-1:0] range_arr_t;

endpackage

/* lake_top.sv */
`timescale 1ns/1ps

module lake_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  lake_pkg::data_t       data_in,
  input  lake_pkg::range_arr_t  wr_ranges,
  input  lake_pkg::time_t       wr_sched_start,
  input  lake_pkg::stride_arr_t wr_sched_strides,
  input  lake_pkg::mem_addr_t   wr_addr_start,
  input  lake_pkg::stride_arr_t wr_addr_strides,
  input  lake_pkg::range_arr_t  rd_ranges,
  input  lake_pkg::time_t       rd_sched_start,
  input  lake_pkg::stride_arr_t rd_sched_strides,
  input  lake_pkg::mem_addr_t   rd_addr_start,
  input  lake_pkg::stride_arr_t rd_addr_strides,
  input  logic                  config_req,
  input  logic                  config_write,
  input  lake_pkg::mem_addr_t   config_addr,
  input  lake_pkg::data_t       config_wdata,
  output lake_pkg::data_t       data_out,
  output logic                  valid_out,
  output logic                  config_ack,
  output lake_pkg::data_t       config_rdata
);
  import lake_pkg::*;

  time_t     cycle_count;   // common time base for both schedules
  logic      wr_fire;
  logic      rd_fire;
  mem_addr_t wr_addr;
  mem_addr_t rd_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_count <= '0;
    end else if (flush) begin
      cycle_count <= '0;
    end else begin
      cycle_count <= cycle_count + 1'b1;
    end
  end

  access_sched wr_sched (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .cycle_count   (cycle_count),
    .ranges        (wr_ranges),
    .sched_start   (wr_sched_start),
    .sched_strides (wr_sched_strides),
    .addr_start    (wr_addr_start),
    .addr_strides  (wr_addr_strides),
    .fire          (wr_fire),
    .addr          (wr_addr)
  );

  access_sched rd_sched (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush         (flush),
    .cycle_count   (cycle_count),
    .ranges        (rd_ranges),
    .sched_start   (rd_sched_start),
    .sched_strides (rd_sched_strides),
    .addr_start    (rd_addr_start),
    .addr_strides  (rd_addr_strides),
    .fire          (rd_fire),
    .addr          (rd_addr)
  );

  ub_storage storage (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (flush),
    .wr_fire      (wr_fire),
    .wr_addr      (wr_addr),
    .data_in      (data_in),
    .rd_fire      (rd_fire),
    .rd_addr      (rd_addr),
    .config_req   (config_req),
    .config_write (config_write),
    .config_addr  (config_addr),
    .config_wdata (config_wdata),
    .config_ack   (config_ack),
    .config_rdata (config_rdata),
    .data_out     (data_out),
    .valid_out    (valid_out)
  );

endmodule

/* loop_iter.sv */
`timescale 1ns/1ps

module loop_iter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush,
  input  logic                 step,
  input  lake_pkg::range_arr_t ranges,
  output lake_pkg::loop_sel_t  sel
);
  import lake_pkg::*;

  localparam int Dims = $bits(range_arr_t) / $bits(time_t);

  range_arr_t      count;    // current index per level
  logic [Dims-1:0] at_last;

  always_comb begin
    for (int i = 0; i < Dims; i++) begin
      at_last[i] = (count[i] == ranges[i]);
    end
  end

  // lowest level that still has room
  always_comb begin
    sel = loop_sel_t'(Dims - 1);  // nest done, outer level keeps counting
    for (int i = Dims - 1; i >= 0; i--) begin
      if (!at_last[i]) begin
        sel = loop_sel_t'(i);
      end
    end
  end

  // advance the selected level and restart the ones below it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (flush) begin
      count <= '0;
    end else if (step) begin
      for (int i = 0; i < Dims; i++) begin
        if (i < int'(sel)) begin
          count[i] <= '0;
        end else if (i == int'(sel)) begin
          count[i] <= count[i] + 1'b1;
        end
      end
    end
  end

endmodule

/* project.f */
+incdir+.
lake_pkg.sv
loop_iter.sv
affine_gen.sv
access_sched.sv
ub_storage.sv
lake_top.sv
lake_chk.sv
tb_lake_top.sv

/* tb_lake_top.sv */
`timescale 1ns/1ps
`include "lake_defs.svh"

module tb_lake_top;
  import lake_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        flush;
  data_t       data_in;
  range_arr_t  wr_ranges;
  range_arr_t  rd_ranges;
  time_t       wr_sched_start;
  time_t       rd_sched_start;
  stride_arr_t wr_sched_strides;
  stride_arr_t rd_sched_strides;
  mem_addr_t   wr_addr_start;
  mem_addr_t   rd_addr_start;
  stride_arr_t wr_addr_strides;
  stride_arr_t rd_addr_strides;
  logic        config_req;
  logic        config_write;
  mem_addr_t   config_addr;
  data_t       config_wdata;
  data_t       data_out;
  logic        valid_out;
  logic        config_ack;
  data_t       config_rdata;

  int unsigned cycles;
  time_t       tb_cnt;       // mirrors the DUT cycle count
  data_t       shadow [`LAKE_MEM_DEPTH];
  time_t       exp_time [$];
  data_t       exp_data [$];

  lake_top uut (.*);

  always #50 clk = ~clk;

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) tb_cnt <= '0;
    else if (flush) tb_cnt <= '0;
    else tb_cnt <= tb_cnt + 1'b1;
  end

  function automatic data_t word_at(time_t t);
    return data_t'(16'hc3a5 + (t * 16'h0107));
  endfunction

  always @(negedge clk) data_in <= word_at(tb_cnt);  // known word per write time

  task automatic stop_fail(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 3000) stop_fail("timeout, the tests did not finish in 3000 cycles");
  end

  task automatic flush_dut();
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    for (int i = 0; i < `LAKE_MEM_DEPTH; i++) shadow[i] = '0;
  endtask

  task automatic idle_streams();
    wr_ranges = '0;
    rd_ranges = '0;
    wr_sched_start = 16'hffff;
    rd_sched_start = 16'hffff;
    wr_sched_strides = '0;
    rd_sched_strides = '0;
    wr_sched_strides[`LAKE_LOOP_DIMS-1] = 16'h4000;
    rd_sched_strides[`LAKE_LOOP_DIMS-1] = 16'h4000;
    wr_addr_start = '0;
    rd_addr_start = '0;
    wr_addr_strides = '0;
    rd_addr_strides = '0;
  endtask

  // steps through the loop nest, filling the shadow memory or the expected reads
  task automatic model_nest(input range_arr_t rg, input time_t s_start, input stride_arr_t s_str,
                            input mem_addr_t a_start, input stride_arr_t a_str, input int n,
                            input logic is_wr);
    time_t     idx [`LAKE_LOOP_DIMS];
    time_t     t;
    mem_addr_t a;
    int        sel;
    for (int d = 0; d < `LAKE_LOOP_DIMS; d++) idx[d] = '0;
    t = s_start;
    a = a_start;
    for (int k = 0; k < n; k++) begin
      if (is_wr) begin
        shadow[a] = word_at(t);
      end else begin
        exp_time.push_back(t);
        exp_data.push_back(shadow[a]);
      end
      sel = `LAKE_LOOP_DIMS - 1;
      for (int i = `LAKE_LOOP_DIMS - 1; i >= 0; i--) if (idx[i] != rg[i]) sel = i;
      for (int i = 0; i < sel; i++) idx[i] = '0;
      idx[sel] = idx[sel] + 16'd1;
      t = t + s_str[sel];
      a = a + a_str[sel][`LAKE_ADDR_W-1:0];
    end
  endtask

  task automatic linear_stream(input logic is_wr, input int n, input time_t t0,
                               input mem_addr_t a0);
    range_arr_t  rg;
    stride_arr_t ss;
    stride_arr_t as;
    rg = '0;
    rg[0] = time_t'(n - 1);
    ss = '0;
    ss[0] = 16'd1;
    ss[`LAKE_LOOP_DIMS-1] = 16'h4000;   // park the stream after the last access
    as = '0;
    as[0] = 16'd1;
    if (is_wr) begin
      wr_ranges = rg;
      wr_sched_start = t0;
      wr_sched_strides = ss;
      wr_addr_start = a0;
      wr_addr_strides = as;
    end else begin
      rd_ranges = rg;
      rd_sched_start = t0;
      rd_sched_strides = ss;
      rd_addr_start = a0;
      rd_addr_strides = as;
    end
    model_nest(rg, t0, ss, a0, as, n, is_wr);
  endtask

  task automatic check_streams(input int n);
    int   idx;
    logic exp_v;
    idx = 0;
    repeat (n) begin
      @(negedge clk);
      exp_v = (idx < exp_time.size()) && (tb_cnt == exp_time[idx] + 16'd1);
      assert (valid_out == exp_v)
        else stop_fail($sformatf("error: valid_out = %h, expected %h", valid_out, exp_v));
      if (exp_v) begin
        assert (data_out == exp_data[idx])
          else stop_fail($sformatf("error: data_out = %h, expected %h", data_out,
                                   exp_data[idx]));
        idx++;
      end
    end
    exp_time.delete();
    exp_data.delete();
  endtask

  task automatic cfg_access(input logic wr, input mem_addr_t a, input data_t wd,
                            output data_t rd, output time_t ack_at);
    config_req = 1'b1;
    config_write = wr;
    config_addr = a;
    config_wdata = wd;
    do @(negedge clk); while (!config_ack);
    rd = config_rdata;
    ack_at = tb_cnt;
    config_req = 1'b0;
    @(negedge clk);
    assert (!config_ack) else stop_fail("config_ack did not fall after config_req dropped");
  endtask

  task automatic reset_values();
    assert (valid_out == 1'b0)
      else stop_fail($sformatf("error: valid_out = %h, expected 0", valid_out));
    assert (config_ack == 1'b0)
      else stop_fail($sformatf("error: config_ack = %h, expected 0", config_ack));
  endtask

  task automatic config_round_trip();
    mem_addr_t base;
    mem_addr_t addrs [6];
    data_t     words [6];
    data_t     rd;
    time_t     at;
    idle_streams();
    flush_dut();
    base = mem_addr_t'($urandom);
    for (int i = 0; i < 6; i++) begin
      addrs[i] = mem_addr_t'(base + i * 37);   // odd step keeps them distinct
      words[i] = data_t'($urandom);
      cfg_access(1'b1, addrs[i], words[i], rd, at);
    end
    for (int i = 0; i < 6; i++) begin
      cfg_access(1'b0, addrs[i], '0, rd, at);
      assert (rd == words[i])
        else stop_fail($sformatf("error: config_rdata = %h, expected %h", rd, words[i]));
    end
  endtask

  task automatic linear_copy();
    flush_dut();
    linear_stream(1'b1, 8, 16'd0, 8'h10);
    linear_stream(1'b0, 8, 16'd12, 8'h10);
    check_streams(30);
  endtask

  task automatic column_major_read();
    flush_dut();
    linear_stream(1'b1, 12, 16'd0, 8'h80);
    // 4 rows of 3 stored row-major, read column by column
    rd_ranges = '0;
    rd_ranges[0] = 16'd3;
    rd_ranges[1] = 16'd2;
    rd_sched_start = 16'd20;
    rd_sched_strides = '0;
    rd_sched_strides[0] = 16'd1;
    rd_sched_strides[1] = 16'd1;
    rd_sched_strides[`LAKE_LOOP_DIMS-1] = 16'h4000;
    rd_addr_start = 8'h80;
    rd_addr_strides = '0;
    rd_addr_strides[0] = 16'd3;
    rd_addr_strides[1] = 16'hfff8;   // back up three rows, one column on
    model_nest(rd_ranges, rd_sched_start, rd_sched_strides, rd_addr_start, rd_addr_strides,
               12, 1'b0);
    check_streams(40);
  endtask

  task automatic config_during_stream();
    data_t rd;
    time_t at;
    flush_dut();
    linear_stream(1'b1, 8, 16'd0, 8'h40);
    linear_stream(1'b0, 8, 16'd10, 8'h40);
    fork
      check_streams(30);
      begin
        repeat (12) @(negedge clk);
        cfg_access(1'b0, 8'h43, '0, rd, at);
        assert (rd == word_at(16'd3))
          else stop_fail($sformatf("error: config_rdata = %h, expected %h", rd,
                                   word_at(16'd3)));
        assert (at >= 16'd19) else stop_fail("config read was acked while the stream fired");
      end
    join
    idle_streams();
    flush_dut();
    cfg_access(1'b0, 8'h43, '0, rd, at);
    assert (rd == '0)
      else stop_fail($sformatf("error: config_rdata = %h, expected 0000", rd));
  endtask

  initial begin
    void'($urandom(32'h2494));
    clk = 1'b0;
    rst_n = 1'b0;
    flush = 1'b0;
    data_in = '0;
    cycles = 0;
    config_req = 1'b0;
    config_write = 1'b0;
    config_addr = '0;
    config_wdata = '0;
    idle_streams();
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_values();
    config_round_trip();
    linear_copy();
    column_major_read();
    config_during_stream();
    $display("** PASS **");
    $finish;
  end

endmodule

/* ub_storage.sv */
`timescale 1ns/1ps

module ub_storage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush,
  input  logic                wr_fire,
  input  lake_pkg::mem_addr_t wr_addr,
  input  lake_pkg::data_t     data_in,
  input  logic                rd_fire,
  input  lake_pkg::mem_addr_t rd_addr,
  input  logic                config_req,
  input  logic                config_write,
  input  lake_pkg::mem_addr_t config_addr,
  input  lake_pkg::data_t     config_wdata,
  output logic                config_ack,
  output lake_pkg::data_t     config_rdata,
  output lake_pkg::data_t     data_out,
  output logic                valid_out
);
  import lake_pkg::*;

  localparam int Depth = 2 ** $bits(mem_addr_t);

  data_t     mem [Depth];
  logic      cfg_grant;
  logic      mem_we;
  mem_addr_t mem_waddr;
  data_t     mem_wdata;

  // config only gets the array in a cycle with no stream access
  assign cfg_grant = config_req && !config_ack && !wr_fire && !rd_fire;

  // single write port shared by stream and config
  always_comb begin
    mem_we    = wr_fire || (cfg_grant && config_write);
    mem_waddr = wr_fire ? wr_addr : config_addr;
    mem_wdata = wr_fire ? data_in : config_wdata;
  end

  always_ff @(posedge clk) begin
    if (flush) begin
      for (int i = 0; i < Depth; i++) begin
        mem[i] <= '0;
      end
    end else if (mem_we) begin
      mem[mem_waddr] <= mem_wdata;
    end
  end

  // reads see the word before a same-cycle write
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      data_out <= mem[rd_addr];
    end
    if (cfg_grant && !config_write) begin
      config_rdata <= mem[config_addr];   // held until the next grant
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_out  <= 1'b0;
      config_ack <= 1'b0;
    end else if (flush) begin
      valid_out  <= 1'b0;
      config_ack <= 1'b0;
    end else begin
      valid_out <= rd_fire;   // one cycle behind the read
      if (cfg_grant) begin
        config_ack <= 1'b1;
      end else if (!config_req) begin
        config_ack <= 1'b0;   // release after req drops
      end
    end
  end

endmodule
